//--- source/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_RESET_PC 32'h0000_0000
// addi x0, x0, 0
`define CORE_NOP      32'h0000_0013
`define CORE_NUM_REGS 32

`endif

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef enum logic [1:0] {
        size_word,
        size_byte,
        size_byte_u
    } mem_size_e;

endpackage : core_pkg

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import core_pkg::*; (
    input  word_t      instr_i,
    input  opcode_e    opcode_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,
    output alu_op_e    alu_op_o,
    output logic       alu_src_imm_o,
    output logic       is_load_o,
    output logic       is_store_o,
    output logic       reg_write_o,
    output logic       use_lui_o,
    output mem_size_e  mem_size_o,
    output word_t      imm_o
);

    word_t   i_imm;
    word_t   s_imm;
    word_t   u_imm;
    alu_op_e f3_op;
    logic    f3_ok;

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign u_imm = {instr_i[31:12], 12'b0};

    // shared funct3 map for register and immediate ops
    always_comb begin
        f3_ok = 1'b1;
        case (funct3_i)
            3'b000:  f3_op = alu_add;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b110:  f3_op = alu_or;
            3'b111:  f3_op = alu_and;
            default: begin
                f3_op = alu_add;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_op_o      = alu_add;
        alu_src_imm_o = 1'b0;
        is_load_o     = 1'b0;
        is_store_o    = 1'b0;
        reg_write_o   = 1'b0;
        use_lui_o     = 1'b0;
        mem_size_o    = size_word;
        imm_o         = i_imm;
        case (opcode_i)
            op_reg: begin
                alu_op_o    = funct7_i[5] ? alu_sub : f3_op;
                reg_write_o = f3_ok && (funct7_i == 7'h00 ||
                              (funct7_i == 7'h20 && funct3_i == 3'b000));
            end
            op_imm: begin
                // no sltiu in this subset
                alu_op_o      = f3_op;
                alu_src_imm_o = 1'b1;
                reg_write_o   = f3_ok && funct3_i != 3'b011;
            end
            op_lui: begin
                use_lui_o   = 1'b1;
                reg_write_o = 1'b1;
                imm_o       = u_imm;
            end
            op_load: begin
                alu_src_imm_o = 1'b1;
                mem_size_o    = (funct3_i == 3'b100) ? size_byte_u :
                                (funct3_i == 3'b000) ? size_byte : size_word;
                is_load_o     = funct3_i inside {3'b000, 3'b010, 3'b100};
                reg_write_o   = is_load_o;
            end
            op_store: begin
                alu_src_imm_o = 1'b1;
                imm_o         = s_imm;
                mem_size_o    = (funct3_i == 3'b000) ? size_byte : size_word;
                is_store_o    = funct3_i inside {3'b000, 3'b010};
            end
            default: ;
        endcase
    end

endmodule : decoder

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs_q [`CORE_NUM_REGS];
    logic  wr_live;

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_live) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through, so ID sees the value retiring in WB
    assign rdata1_o = (wr_live && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (wr_live && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule : regfile

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,
    input  reg_idx_t ex_rs1_i,
    input  reg_idx_t ex_rs2_i,
    input  reg_idx_t ex_rd_i,
    input  reg_idx_t mem_rd_i,
    input  reg_idx_t wb_rd_i,
    input  logic     ex_is_load_i,
    input  logic     mem_reg_write_i,
    input  logic     wb_reg_write_i,
    output logic     stall_o,
    output fwd_sel_e fwd1_sel_o,
    output fwd_sel_e fwd2_sel_o
);

    logic mem_live;
    logic wb_live;

    assign mem_live = mem_reg_write_i && (mem_rd_i != '0);
    assign wb_live  = wb_reg_write_i && (wb_rd_i != '0);

    // load result is not ready until WB
    assign stall_o = ex_is_load_i && (ex_rd_i != '0) &&
                     (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

    // younger result in MEM wins over WB
    always_comb begin
        fwd1_sel_o = fwd_none;
        fwd2_sel_o = fwd_none;
        if (mem_live && mem_rd_i == ex_rs1_i) begin
            fwd1_sel_o = fwd_mem;
        end else if (wb_live && wb_rd_i == ex_rs1_i) begin
            fwd1_sel_o = fwd_wb;
        end
        if (mem_live && mem_rd_i == ex_rs2_i) begin
            fwd2_sel_o = fwd_mem;
        end else if (wb_live && wb_rd_i == ex_rs2_i) begin
            fwd2_sel_o = fwd_wb;
        end
    end

endmodule : hazard_unit

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module datapath import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    // ID-stage controls
    input  alu_op_e    alu_op_i,
    input  logic       alu_src_imm_i,
    input  logic       is_load_i,
    input  logic       is_store_i,
    input  logic       reg_write_i,
    input  logic       use_lui_i,
    input  mem_size_e  mem_size_i,
    input  word_t      imm_i,
    input  logic       stall_i,
    input  fwd_sel_e   fwd1_sel_i,
    input  fwd_sel_e   fwd2_sel_i,
    input  word_t      imem_rdata_i,
    input  word_t      dmem_rdata_i,
    output opcode_e    opcode_o,
    output logic [2:0] funct3_o,
    output logic [6:0] funct7_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output reg_idx_t   rd_o,
    output word_t      instr_o,
    // to hazard unit
    output reg_idx_t   ex_rs1_o,
    output reg_idx_t   ex_rs2_o,
    output reg_idx_t   ex_rd_o,
    output logic       ex_is_load_o,
    output reg_idx_t   mem_rd_o,
    output logic       mem_reg_write_o,
    output reg_idx_t   wb_rd_o,
    output logic       wb_reg_write_o,
    output word_t      imem_addr_o,
    output word_t      dmem_addr_o,
    output word_t      dmem_wdata_o,
    output byte_mask_t dmem_wmask_o,
    output byte_mask_t dmem_rmask_o,
    output logic       commit_valid_o,
    output reg_idx_t   commit_rd_o,
    output word_t      commit_data_o
);

    word_t      pc_q;
    word_t      if_id_instr_q;
    word_t      rf_rdata1, rf_rdata2;

    logic       ex_reg_write_q, ex_is_load_q, ex_is_store_q, ex_use_lui_q, ex_src_imm_q;
    alu_op_e    ex_alu_op_q;
    mem_size_e  ex_size_q;
    reg_idx_t   ex_rd_q, ex_rs1_q, ex_rs2_q;
    word_t      ex_rs1_data_q, ex_rs2_data_q, ex_imm_q;
    word_t      op_a, op_b, alu_b, alu_out;

    logic       mem_reg_write_q, mem_is_load_q, mem_is_store_q, mem_use_lui_q;
    mem_size_e  mem_size_q;
    reg_idx_t   mem_rd_q;
    word_t      mem_alu_q, mem_store_q, mem_imm_q, mem_fwd_data;
    byte_mask_t lane_mask;

    logic       wb_reg_write_q, wb_is_load_q, wb_use_lui_q;
    mem_size_e  wb_size_q;
    reg_idx_t   wb_rd_q;
    logic [1:0] wb_lane_q;
    word_t      wb_alu_q, wb_imm_q, wb_rdata_q, wb_data;
    logic [7:0] wb_byte;

    function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                       word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // IF and IF/ID
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= `CORE_RESET_PC;
            if_id_instr_q <= `CORE_NOP;
        end else if (!stall_i) begin
            pc_q          <= pc_q + 32'd4;
            if_id_instr_q <= imem_rdata_i;
        end
    end

    assign imem_addr_o = pc_q;
    assign instr_o     = if_id_instr_q;
    assign opcode_o    = opcode_e'(if_id_instr_q[6:0]);
    assign rd_o        = if_id_instr_q[11:7];
    assign funct3_o    = if_id_instr_q[14:12];
    assign rs1_o       = if_id_instr_q[19:15];
    assign rs2_o       = if_id_instr_q[24:20];
    assign funct7_o    = if_id_instr_q[31:25];

    regfile regfile_inst (
        .clk, .arst_n_i,
        .we_i(wb_reg_write_q), .waddr_i(wb_rd_q), .wdata_i(wb_data),
        .raddr1_i(rs1_o), .raddr2_i(rs2_o),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    // ID/EX, a stall drops a bubble in
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_reg_write_q <= 1'b0;
            ex_is_load_q   <= 1'b0;
            ex_is_store_q  <= 1'b0;
            ex_use_lui_q   <= 1'b0;
            ex_src_imm_q   <= 1'b0;
            ex_alu_op_q    <= alu_add;
            ex_size_q      <= size_word;
            ex_rd_q        <= '0;
            ex_rs1_q       <= '0;
            ex_rs2_q       <= '0;
        end else begin
            ex_reg_write_q <= reg_write_i && !stall_i;
            ex_is_load_q   <= is_load_i && !stall_i;
            ex_is_store_q  <= is_store_i && !stall_i;
            ex_use_lui_q   <= use_lui_i;
            ex_src_imm_q   <= alu_src_imm_i;
            ex_alu_op_q    <= alu_op_i;
            ex_size_q      <= mem_size_i;
            ex_rd_q        <= rd_o;
            ex_rs1_q       <= rs1_o;
            ex_rs2_q       <= rs2_o;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1_data_q <= rf_rdata1;
        ex_rs2_data_q <= rf_rdata2;
        ex_imm_q      <= imm_i;
    end

    // EX
    assign mem_fwd_data = mem_use_lui_q ? mem_imm_q : mem_alu_q;
    assign op_a  = fwd_pick(fwd1_sel_i, ex_rs1_data_q, mem_fwd_data, wb_data);
    assign op_b  = fwd_pick(fwd2_sel_i, ex_rs2_data_q, mem_fwd_data, wb_data);
    assign alu_b = ex_src_imm_q ? ex_imm_q : op_b;

    always_comb begin
        case (ex_alu_op_q)
            alu_sub:  alu_out = op_a - alu_b;
            alu_and:  alu_out = op_a & alu_b;
            alu_or:   alu_out = op_a | alu_b;
            alu_xor:  alu_out = op_a ^ alu_b;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_sltu: alu_out = {31'b0, op_a < alu_b};
            default:  alu_out = op_a + alu_b;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_reg_write_q <= 1'b0;
            mem_is_load_q   <= 1'b0;
            mem_is_store_q  <= 1'b0;
            mem_use_lui_q   <= 1'b0;
            mem_size_q      <= size_word;
            mem_rd_q        <= '0;
        end else begin
            mem_reg_write_q <= ex_reg_write_q;
            mem_is_load_q   <= ex_is_load_q;
            mem_is_store_q  <= ex_is_store_q;
            mem_use_lui_q   <= ex_use_lui_q;
            mem_size_q      <= ex_size_q;
            mem_rd_q        <= ex_rd_q;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_q   <= alu_out;
        mem_store_q <= op_b;
        mem_imm_q   <= ex_imm_q;
    end

    // MEM lane masks and store shift
    assign dmem_addr_o  = mem_alu_q;
    assign lane_mask    = 4'b0001 << mem_alu_q[1:0];
    assign dmem_wdata_o = (mem_size_q == size_word) ? mem_store_q :
                          mem_store_q << {mem_alu_q[1:0], 3'b000};
    assign dmem_wmask_o = !mem_is_store_q ? 4'b0000 :
                          (mem_size_q == size_word) ? 4'b1111 : lane_mask;
    assign dmem_rmask_o = !mem_is_load_q ? 4'b0000 :
                          (mem_size_q == size_word) ? 4'b1111 : lane_mask;

    // MEM/WB
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_reg_write_q <= 1'b0;
            wb_is_load_q   <= 1'b0;
            wb_use_lui_q   <= 1'b0;
            wb_size_q      <= size_word;
            wb_rd_q        <= '0;
        end else begin
            wb_reg_write_q <= mem_reg_write_q;
            wb_is_load_q   <= mem_is_load_q;
            wb_use_lui_q   <= mem_use_lui_q;
            wb_size_q      <= mem_size_q;
            wb_rd_q        <= mem_rd_q;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu_q   <= mem_alu_q;
        wb_imm_q   <= mem_imm_q;
        wb_rdata_q <= dmem_rdata_i;
        wb_lane_q  <= mem_alu_q[1:0];
    end

    // WB mux with byte extract
    assign wb_byte = wb_rdata_q[{wb_lane_q, 3'b000} +: 8];

    always_comb begin
        if (wb_use_lui_q) begin
            wb_data = wb_imm_q;
        end else if (!wb_is_load_q) begin
            wb_data = wb_alu_q;
        end else begin
            case (wb_size_q)
                size_byte:   wb_data = {{24{wb_byte[7]}}, wb_byte};
                size_byte_u: wb_data = {24'b0, wb_byte};
                default:     wb_data = wb_rdata_q;
            endcase
        end
    end

    assign commit_valid_o = wb_reg_write_q && (wb_rd_q != '0);
    assign commit_rd_o    = wb_rd_q;
    assign commit_data_o  = wb_data;

    assign ex_rs1_o        = ex_rs1_q;
    assign ex_rs2_o        = ex_rs2_q;
    assign ex_rd_o         = ex_rd_q;
    assign ex_is_load_o    = ex_is_load_q;
    assign mem_rd_o        = mem_rd_q;
    assign mem_reg_write_o = mem_reg_write_q;
    assign wb_rd_o         = wb_rd_q;
    assign wb_reg_write_o  = wb_reg_write_q;

endmodule : datapath

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    output word_t      imem_addr_o,
    input  word_t      imem_rdata_i,
    output word_t      dmem_addr_o,
    output word_t      dmem_wdata_o,
    output byte_mask_t dmem_wmask_o,
    output byte_mask_t dmem_rmask_o,
    input  word_t      dmem_rdata_i,
    output logic       commit_valid_o,
    output reg_idx_t   commit_rd_o,
    output word_t      commit_data_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1, rs2;
    word_t      instr, imm;
    alu_op_e    alu_op;
    mem_size_e  mem_size;
    logic       alu_src_imm, is_load, is_store, reg_write, use_lui;
    logic       stall;
    fwd_sel_e   fwd1_sel, fwd2_sel;
    reg_idx_t   ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
    logic       ex_is_load, mem_reg_write, wb_reg_write;

    decoder decoder_inst (
        .instr_i(instr), .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
        .alu_op_o(alu_op), .alu_src_imm_o(alu_src_imm),
        .is_load_o(is_load), .is_store_o(is_store),
        .reg_write_o(reg_write), .use_lui_o(use_lui),
        .mem_size_o(mem_size), .imm_o(imm)
    );

    hazard_unit hazard_unit_inst (
        .id_rs1_i(rs1), .id_rs2_i(rs2),
        .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
        .mem_rd_i(mem_rd), .wb_rd_i(wb_rd),
        .ex_is_load_i(ex_is_load),
        .mem_reg_write_i(mem_reg_write), .wb_reg_write_i(wb_reg_write),
        .stall_o(stall), .fwd1_sel_o(fwd1_sel), .fwd2_sel_o(fwd2_sel)
    );

    datapath datapath_inst (
        .clk, .arst_n_i,
        .alu_op_i(alu_op), .alu_src_imm_i(alu_src_imm),
        .is_load_i(is_load), .is_store_i(is_store),
        .reg_write_i(reg_write), .use_lui_i(use_lui),
        .mem_size_i(mem_size), .imm_i(imm),
        .stall_i(stall), .fwd1_sel_i(fwd1_sel), .fwd2_sel_i(fwd2_sel),
        .imem_rdata_i, .dmem_rdata_i,
        .opcode_o(opcode), .funct3_o(funct3), .funct7_o(funct7),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(), .instr_o(instr),
        .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
        .ex_is_load_o(ex_is_load),
        .mem_rd_o(mem_rd), .mem_reg_write_o(mem_reg_write),
        .wb_rd_o(wb_rd), .wb_reg_write_o(wb_reg_write),
        .imem_addr_o, .dmem_addr_o, .dmem_wdata_o,
        .dmem_wmask_o, .dmem_rmask_o,
        .commit_valid_o, .commit_rd_o, .commit_data_o
    );

endmodule : core_top

`default_nettype wire

//--- sim/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker import core_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input byte_mask_t wmask_i,
    input byte_mask_t rmask_i,
    input logic       commit_valid_i,
    input reg_idx_t   commit_rd_i
);

    int fail_cnt = 0;

    // one memory access per cycle
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !((wmask_i != '0) && (rmask_i != '0)))
        else begin
            $error("read and write masks active together");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_i |-> (commit_rd_i != '0))
        else begin
            $error("commit reported for x0");
            fail_cnt++;
        end

    // pipeline is still filling with bubbles
    assert property (@(posedge clk)
        $rose(arst_n_i) |-> !commit_valid_i [*4])
        else begin
            $error("commit too soon after reset release");
            fail_cnt++;
        end

endmodule : core_checker

bind core_top core_checker core_checker_inst (
    .clk, .arst_n_i,
    .wmask_i(dmem_wmask_o), .rmask_i(dmem_rmask_o),
    .commit_valid_i(commit_valid_o), .commit_rd_i(commit_rd_o)
);

`default_nettype wire

//--- sim/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_tb import core_pkg::*; ();

    logic       clk;
    logic       arst_n;
    word_t      imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata, commit_data;
    byte_mask_t dmem_wmask, dmem_rmask;
    logic       commit_valid;
    reg_idx_t   commit_rd;

    word_t imem [256];
    word_t dmem [256];
    word_t ref_mem [256];
    word_t ref_regs [32];
    int    pc_idx, stall_n, cyc;
    int    err_cnt, chk_cnt, tests_run, tests_bad;
    reg_idx_t last_load_rd;

    reg_idx_t   exp_rd[$], got_rd[$];
    word_t      exp_data[$], got_data[$];
    int         exp_cyc[$], got_cyc[$];
    byte_mask_t exp_wm[$], got_wm[$], exp_rm[$], got_rm[$];
    word_t      exp_addr[$], got_addr[$], exp_wd[$], got_wd[$];

    core_top core_top_inst (
        .clk, .arst_n_i(arst_n),
        .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_wmask_o(dmem_wmask), .dmem_rmask_o(dmem_rmask),
        .dmem_rdata_i(dmem_rdata),
        .commit_valid_o(commit_valid), .commit_rd_o(commit_rd), .commit_data_o(commit_data)
    );

    always #20 clk = ~clk;

    // same-cycle memories
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem_wmask[i]) begin
                dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
            end
        end
    end

    // cycle 0 is the first cycle after reset release
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            got_rd.push_back(commit_rd);
            got_data.push_back(commit_data);
            got_cyc.push_back(cyc);
        end
        if (arst_n && (dmem_wmask != '0 || dmem_rmask != '0)) begin
            got_wm.push_back(dmem_wmask);
            got_rm.push_back(dmem_rmask);
            got_addr.push_back(dmem_addr);
            got_wd.push_back(dmem_wdata);
        end
    end

    task automatic check_word(string what, word_t got, word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_mask(string what, byte_mask_t got, byte_mask_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_reg(string what, reg_idx_t got, reg_idx_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got x%0d expected x%0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I result rules
    function automatic word_t isa_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic start_program();
        @(posedge clk);
        #1;
        for (int i = 0; i < 256; i++) begin
            imem[i]    = `CORE_NOP;
            dmem[i]    = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        pc_idx       = 0;
        stall_n      = 0;
        last_load_rd = '0;
        exp_rd.delete();
        exp_data.delete();
        exp_cyc.delete();
        exp_wm.delete();
        exp_rm.delete();
        exp_addr.delete();
        exp_wd.delete();
    endtask

    // a read of the previous load's rd costs one bubble
    task automatic note_reads(reg_idx_t rs1, reg_idx_t rs2);
        if (last_load_rd != '0 && (rs1 == last_load_rd || rs2 == last_load_rd)) begin
            stall_n++;
        end
    endtask

    task automatic emit(word_t instr, reg_idx_t rd, word_t value);
        imem[pc_idx] = instr;
        if (rd != '0) begin
            ref_regs[rd] = value;
            exp_rd.push_back(rd);
            exp_data.push_back(value);
            exp_cyc.push_back(pc_idx + 4 + stall_n);
        end
        pc_idx++;
        last_load_rd = '0;
    endtask

    task automatic do_lui(reg_idx_t rd, logic [19:0] imm20);
        emit({imm20, rd, 7'b0110111}, rd, {imm20, 12'b0});
    endtask

    task automatic do_opi(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        note_reads(rs1, 5'd0);
        emit({imm, rs1, f3, rd, 7'b0010011}, rd, isa_alu(f3, 1'b0, ref_regs[rs1], sext12(imm)));
    endtask

    task automatic do_op(logic sub, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        logic [6:0] f7;
        f7 = sub ? 7'h20 : 7'h00;
        note_reads(rs1, rs2);
        emit({f7, rs2, rs1, f3, rd, 7'b0110011}, rd,
             isa_alu(f3, sub, ref_regs[rs1], ref_regs[rs2]));
    endtask

    task automatic do_load(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        word_t      addr;
        word_t      w;
        word_t      v;
        logic [7:0] b;
        addr = ref_regs[rs1] + sext12(imm);
        w    = ref_mem[addr[9:2]];
        b    = w[{addr[1:0], 3'b000} +: 8];
        case (f3)
            3'b000:  v = {{24{b[7]}}, b};
            3'b100:  v = {24'b0, b};
            default: v = w;
        endcase
        note_reads(rs1, 5'd0);
        emit({imm, rs1, f3, rd, 7'b0000011}, rd, v);
        last_load_rd = rd;
        exp_wm.push_back(4'b0000);
        exp_rm.push_back((f3 == 3'b010) ? 4'b1111 : 4'b0001 << addr[1:0]);
        exp_addr.push_back(addr);
        exp_wd.push_back('0);
    endtask

    task automatic do_store(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        word_t      addr;
        word_t      wd;
        byte_mask_t m;
        addr = ref_regs[rs1] + sext12(imm);
        if (f3 == 3'b010) begin
            m  = 4'b1111;
            wd = ref_regs[rs2];
        end else begin
            m  = 4'b0001 << addr[1:0];
            wd = ref_regs[rs2] << {addr[1:0], 3'b000};
        end
        for (int i = 0; i < 4; i++) begin
            if (m[i]) begin
                ref_mem[addr[9:2]][8*i +: 8] = wd[8*i +: 8];
            end
        end
        note_reads(rs1, rs2);
        emit({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011}, 5'd0, '0);
        exp_wm.push_back(m);
        exp_rm.push_back(4'b0000);
        exp_addr.push_back(addr);
        exp_wd.push_back(wd);
    endtask

    task automatic load_const(reg_idx_t rd, word_t val);
        word_t upper;
        upper = (val + 32'h800) >> 12;
        do_lui(rd, upper[19:0]);
        do_opi(3'b000, rd, rd, val[11:0]);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        got_rd.delete();
        got_data.delete();
        got_cyc.delete();
        got_wm.delete();
        got_rm.delete();
        got_addr.delete();
        got_wd.delete();
        repeat (3) begin
            @(negedge clk);
            check_word("imem_addr in reset", imem_addr, `CORE_RESET_PC);
            check_word("commit_valid in reset", word_t'(commit_valid), '0);
            check_mask("wmask in reset", dmem_wmask, '0);
            check_mask("rmask in reset", dmem_rmask, '0);
            @(posedge clk);
        end
        #1;
        arst_n = 1'b1;
    endtask

    task automatic finish_test(string name, int base_err);
        tests_run++;
        if (err_cnt == base_err) begin
            $display("%-12s ok", name);
        end else begin
            $display("%-12s %0d errors", name, err_cnt - base_err);
            tests_bad++;
        end
    endtask

    task automatic run_and_check(string name);
        int base_err;
        int t;
        int i;
        base_err = err_cnt;
        apply_reset();
        t = 0;
        while (got_rd.size() < exp_rd.size() && t < 300) begin
            @(posedge clk);
            t++;
        end
        if (got_rd.size() < exp_rd.size()) begin
            $display("%s: timed out with %0d of %0d commits", name, got_rd.size(), exp_rd.size());
            err_cnt++;
        end
        // drain, then look for stray commits
        repeat (6) @(posedge clk);
        if (got_rd.size() != exp_rd.size()) begin
            $display("%s: saw %0d commits, expected %0d", name, got_rd.size(), exp_rd.size());
            err_cnt++;
        end
        for (i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
            check_reg("commit rd", got_rd[i], exp_rd[i]);
            check_word("commit data", got_data[i], exp_data[i]);
            check_word("commit cycle", word_t'(got_cyc[i]), word_t'(exp_cyc[i]));
        end
        if (got_wm.size() != exp_wm.size()) begin
            $display("%s: saw %0d memory accesses, expected %0d", name, got_wm.size(),
                     exp_wm.size());
            err_cnt++;
        end
        for (i = 0; i < exp_wm.size() && i < got_wm.size(); i++) begin
            check_mask("dmem wmask", got_wm[i], exp_wm[i]);
            check_mask("dmem rmask", got_rm[i], exp_rm[i]);
            check_word("dmem addr", got_addr[i], exp_addr[i]);
            if (exp_wm[i] != '0) begin
                check_word("dmem wdata", got_wd[i], exp_wd[i]);
            end
        end
        finish_test(name, base_err);
    endtask

    task automatic test_reset();
        int base_err;
        base_err = err_cnt;
        start_program();
        apply_reset();
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            check_word("pc step", imem_addr, `CORE_RESET_PC + 32'd4 * k);
            check_word("commit_valid after reset", word_t'(commit_valid), '0);
            check_mask("wmask after reset", dmem_wmask, '0);
            check_mask("rmask after reset", dmem_rmask, '0);
        end
        finish_test("reset", base_err);
    endtask

    task automatic test_alu();
        word_t r;
        start_program();
        for (int k = 0; k < 3; k++) begin
            load_const(5'd1, $urandom);
            load_const(5'd2, $urandom);
            do_op(1'b0, 3'b000, 5'd10, 5'd1, 5'd2);
            do_op(1'b1, 3'b000, 5'd11, 5'd1, 5'd2);
            do_op(1'b0, 3'b111, 5'd12, 5'd1, 5'd2);
            do_op(1'b0, 3'b110, 5'd13, 5'd1, 5'd2);
            do_op(1'b0, 3'b100, 5'd14, 5'd1, 5'd2);
            do_op(1'b0, 3'b010, 5'd15, 5'd1, 5'd2);
            do_op(1'b0, 3'b011, 5'd16, 5'd1, 5'd2);
            r = $urandom;
            do_opi(3'b000, 5'd17, 5'd1, r[11:0]);
            do_opi(3'b111, 5'd18, 5'd2, r[23:12]);
            do_opi(3'b110, 5'd19, 5'd1, r[23:12]);
            do_opi(3'b100, 5'd20, 5'd2, r[11:0]);
            do_opi(3'b010, 5'd21, 5'd1, r[31:20]);
        end
        run_and_check("alu");
    endtask

    task automatic test_forwarding();
        start_program();
        load_const(5'd3, $urandom);
        do_opi(3'b000, 5'd4, 5'd3, 12'h123);
        do_op(1'b0, 3'b000, 5'd5, 5'd4, 5'd3);
        do_op(1'b1, 3'b000, 5'd6, 5'd5, 5'd4);
        do_op(1'b0, 3'b100, 5'd7, 5'd6, 5'd5);
        do_op(1'b0, 3'b110, 5'd8, 5'd7, 5'd6);
        do_op(1'b0, 3'b111, 5'd9, 5'd8, 5'd7);
        do_op(1'b0, 3'b010, 5'd10, 5'd9, 5'd8);
        do_op(1'b0, 3'b000, 5'd3, 5'd3, 5'd3);
        do_op(1'b0, 3'b000, 5'd3, 5'd3, 5'd3);
        // x0 as a destination must stay invisible
        do_opi(3'b000, 5'd0, 5'd3, 12'h7ff);
        do_op(1'b0, 3'b000, 5'd11, 5'd0, 5'd3);
        run_and_check("forwarding");
    endtask

    task automatic test_load_use();
        start_program();
        load_const(5'd7, $urandom);
        do_opi(3'b000, 5'd8, 5'd0, 12'h040);
        do_store(3'b010, 5'd7, 5'd8, 12'h000);
        do_load(3'b010, 5'd5, 5'd8, 12'h000);
        do_op(1'b0, 3'b000, 5'd6, 5'd5, 5'd7);
        do_opi(3'b000, 5'd9, 5'd0, 12'h001);
        do_opi(3'b000, 5'd10, 5'd6, 12'h002);
        run_and_check("load_use");
    endtask

    task automatic test_byte_access();
        start_program();
        load_const(5'd7, $urandom | 32'h8080_8080);
        load_const(5'd9, $urandom);
        do_opi(3'b000, 5'd8, 5'd0, 12'h080);
        do_store(3'b010, 5'd7, 5'd8, 12'h000);
        for (int lane = 0; lane < 4; lane++) begin
            do_store(3'b000, 5'd9, 5'd8, 12'(16 + lane));
        end
        for (int lane = 0; lane < 4; lane++) begin
            do_load(3'b000, reg_idx_t'(12 + lane), 5'd8, 12'(lane));
        end
        for (int lane = 0; lane < 4; lane++) begin
            do_load(3'b100, reg_idx_t'(16 + lane), 5'd8, 12'(lane));
        end
        do_load(3'b010, 5'd20, 5'd8, 12'h010);
        run_and_check("byte_access");
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        err_cnt   = 0;
        chk_cnt   = 0;
        tests_run = 0;
        tests_bad = 0;
        void'($urandom(16));
        test_reset();
        test_alu();
        test_forwarding();
        test_load_use();
        test_byte_access();
        // assertion failures from the bound checker count as errors
        err_cnt += core_top_inst.core_checker_inst.fail_cnt;
        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule : core_tb

`default_nettype wire

//--- core_top.f
+incdir+source
source/core_pkg.sv
source/decoder.sv
source/regfile.sv
source/hazard_unit.sv
source/datapath.sv
source/core_top.sv
sim/core_checker.sv
sim/core_tb.sv

//--- Bender.yml
package:
  name: core_top

export_include_dirs:
  - source

sources:
  - files:
      - source/core_pkg.sv
      - source/decoder.sv
      - source/regfile.sv
      - source/hazard_unit.sv
      - source/datapath.sv
      - source/core_top.sv
  - target: simulation
    files:
      - sim/core_checker.sv
      - sim/core_tb.sv
